// File: pipeHazard.f
+incdir+verilog
verilog/pipePkg.sv
verilog/pipeCtrl.sv
verilog/stageReg.sv
verilog/fetchPc.sv
verilog/hazardDetect.sv
verilog/mulDivSeq.sv
verilog/pipeTop.sv
sim/pipe_props.sv
sim/pipeChecker.sv
sim/pipeTb.sv

// File: sim/pipeChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipeChecker (
    input  logic                   clk,
    input  logic                   rstN,
    input  pipePkg::instFields_t   fetchInst,
    input  logic                   excFlush,
    input  logic                   mispredict,
    input  logic [`PIPE_PC_W-1:0]  mispTarget,
    input  logic                   iBusy,
    input  logic                   dBusy,
    input  logic                   iTlbStall,
    input  logic                   dTlbStall,
    input  logic                   wbRetire,
    input  logic [`PIPE_PC_W-1:0]  wbPc,
    input  logic [`PIPE_REG_W-1:0] wbDest,
    input  logic                   iReqValid,
    input  logic                   dReqValid,
    input  logic                   iCacheStall,
    input  logic                   dCacheStall,
    output int                     errCount,
    output int                     retired
);

    // wr flush disWr for each stage from if down to wb
    localparam logic [17:0] RowBusy = 18'b000_000_001_001_000_001;
    localparam logic [17:0] RowExc  = 18'b010_010_011_011_100_100;
    localparam logic [17:0] RowHz2  = 18'b000_000_000_001_110_100;
    localparam logic [17:0] RowHz1  = 18'b000_000_001_110_100_100;
    localparam logic [17:0] RowHz0  = 18'b000_000_110_100_100_100;
    localparam logic [17:0] RowMisp = 18'b010_010_100_100_100_100;
    localparam logic [17:0] RowRun  = 18'b100_100_100_100_100_100;

    logic [`PIPE_PC_W-1:0] pc;
    pipePkg::pcToken_t     ifT;
    pipePkg::instToken_t   idT;
    pipePkg::instToken_t   exT;
    pipePkg::instToken_t   meT;
    pipePkg::instToken_t   m2T;
    pipePkg::instToken_t   wbT;
    int                    mdLeft;    // busy cycles still owed
    logic                  mdDone;

    initial begin
        errCount = 0;
        retired  = 0;
    end

    function automatic logic readsLoad(
        input pipePkg::instToken_t younger,
        input pipePkg::instToken_t older
    );
        logic hit;
        hit = younger.valid && older.valid && older.fields.kind == pipePkg::loadOp;
        hit = hit && older.fields.dest != '0;
        return hit && (older.fields.dest == younger.fields.src1
                    || older.fields.dest == younger.fields.src2);
    endfunction

    function automatic pipePkg::instToken_t advance(
        input pipePkg::instToken_t cur,
        input pipePkg::instToken_t nxt,
        input pipePkg::stageCtrl_t c
    );
        if (c.flush) begin
            return '0;
        end
        return c.wr ? nxt : cur;
    endfunction

    task automatic compareSignal(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
            errCount++;
        end
    endtask

    // outputs settle by the falling edge and inputs hold until the next rise
    always @(negedge clk) begin : model
        pipePkg::stageCtrl_t [5:0] c;
        pipePkg::hazardReq_t       hz;
        logic                      exc;
        logic                      busy;
        logic                      anyHz;
        logic                      preIfWr;
        logic                      start;
        logic                      retire;
        if (!rstN) begin
            pc     = `PIPE_RESET_PC;
            ifT    = '0;
            idT    = '0;
            exT    = '0;
            meT    = '0;
            m2T    = '0;
            wbT    = '0;
            mdLeft = 0;
            mdDone = 1'b0;
            compareSignal("wbRetire", wbRetire, 0);
            compareSignal("dReqValid", dReqValid, 0);
        end else begin
            exc         = (excFlush == `PIPE_FLUSH_ENABLE);
            busy        = iBusy || dBusy || iTlbStall || dTlbStall || mdLeft != 0;
            hz.withExe  = readsLoad(idT, exT);
            hz.withMem  = readsLoad(idT, meT);
            hz.withMem2 = readsLoad(idT, m2T);
            anyHz       = hz.withExe || hz.withMem || hz.withMem2;
            if (busy) begin
                c = RowBusy;
            end else if (exc) begin
                c = RowExc;
            end else if (hz.withMem2) begin
                c = RowHz2;
            end else if (hz.withMem) begin
                c = RowHz1;
            end else if (hz.withExe) begin
                c = RowHz0;
            end else begin
                c = mispredict ? RowMisp : RowRun;
            end
            preIfWr = !busy && (exc || !anyHz);
            retire  = wbT.valid && !c[0].disWr;
            compareSignal("wbRetire", wbRetire, retire);
            if (retire) begin
                compareSignal("wbPc", wbPc, wbT.pc);
                compareSignal("wbDest", wbDest, wbT.fields.dest);
                retired++;
            end
            compareSignal("iReqValid", iReqValid, !(exc || anyHz || mispredict));
            compareSignal("dReqValid", dReqValid, !exc && meT.valid && !c[2].disWr
                && (meT.fields.kind == pipePkg::loadOp || meT.fields.kind == pipePkg::storeOp));
            compareSignal("iCacheStall", iCacheStall, busy || (!exc && anyHz));
            compareSignal("dCacheStall", dCacheStall, busy);

            start = exT.valid && exT.fields.kind == pipePkg::mulDivOp && !c[3].disWr
                 && mdLeft == 0 && !mdDone;
            mdDone = c[3].wr ? 1'b0 : (start ? 1'b1 : mdDone);
            if (start) begin
                mdLeft = `PIPE_MULDIV_CYC;
            end else if (mdLeft > 0) begin
                mdLeft--;
            end

            wbT = advance(wbT, m2T, c[0]);    // back to front so old values feed forward
            m2T = advance(m2T, meT, c[1]);
            meT = advance(meT, exT, c[2]);
            exT = advance(exT, idT, c[3]);
            idT = advance(idT, '{valid: ifT.valid, pc: ifT.pc, fields: fetchInst}, c[4]);
            if (c[5].flush) begin
                ifT = '0;
            end else if (c[5].wr) begin
                ifT = '{valid: 1'b1, pc: pc};
            end
            if (exc) begin
                pc = `PIPE_EXC_VECTOR;
            end else if (mispredict) begin
                pc = mispTarget;
            end else if (preIfWr) begin
                pc = pc + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/pipeTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipeTb;

    logic                   clk = 1'b0;
    logic                   rstN;
    pipePkg::instFields_t   fetchInst;
    logic                   excFlush;
    logic                   mispredict;
    logic [`PIPE_PC_W-1:0]  mispTarget;
    logic                   iBusy;
    logic                   dBusy;
    logic                   iTlbStall;
    logic                   dTlbStall;
    logic                   wbRetire;
    logic [`PIPE_PC_W-1:0]  wbPc;
    logic [`PIPE_REG_W-1:0] wbDest;
    logic                   iReqValid;
    logic                   dReqValid;
    logic                   iCacheStall;
    logic                   dCacheStall;
    int                     errCount;
    int                     retired;
    int                     seed;
    int                     cycles;
    bit                     timedOut;

    pipeTop dut0 (.*);

    pipeChecker check0 (.*);

    always #50 clk = ~clk;

    function automatic logic rollUnder(input int pct);
        return ({$random(seed)} % 100) < pct;
    endfunction

    task automatic driveRandom();
        int k;
        k = {$random(seed)} % 8;
        fetchInst.kind <= (k < 2) ? pipePkg::aluOp : (k < 5) ? pipePkg::loadOp
                        : (k < 7) ? pipePkg::storeOp : pipePkg::mulDivOp;
        fetchInst.src1 <= `PIPE_REG_W'({$random(seed)} % 8);    // small register set for many hazards
        fetchInst.src2 <= `PIPE_REG_W'({$random(seed)} % 8);
        fetchInst.dest <= `PIPE_REG_W'({$random(seed)} % 8);
        iBusy      <= rollUnder(10);
        dBusy      <= rollUnder(10);
        iTlbStall  <= rollUnder(10);
        dTlbStall  <= rollUnder(10);
        excFlush   <= rollUnder(5);
        mispredict <= rollUnder(5);
        mispTarget <= $random(seed) & 32'hFFFF_FFFC;
    endtask

    initial begin
        seed       = 49;
        rstN       = 1'b0;
        fetchInst  = '0;
        excFlush   = 1'b0;
        mispredict = 1'b0;
        mispTarget = '0;
        iBusy      = 1'b0;
        dBusy      = 1'b0;
        iTlbStall  = 1'b0;
        dTlbStall  = 1'b0;
        timedOut   = 1'b0;
        cycles     = 0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        while (retired < 400 && cycles < 20000) begin
            @(posedge clk);
            if (cycles >= 8) begin
                driveRandom();    // quiet start lets the first token retire undisturbed
            end
            cycles++;
        end
        if (retired < 400) begin
            $display("timeout: only %0d of 400 instructions retired in %0d cycles",
                     retired, cycles);
            timedOut = 1'b1;
        end
        $display("errors: mismatches=%0d timeouts=%0d retired=%0d", errCount, timedOut,
                 retired);
        if (errCount == 0 && !timedOut) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/pipe_props.sv
`timescale 1ns/1ps
`default_nettype none

module pipeProps (
    input logic                clk,
    input logic                rstN,
    input logic                iBusy,
    input logic                dBusy,
    input logic                iTlbStall,
    input logic                dTlbStall,
    input logic                mulDivBusy,
    input logic                preIfWr,
    input pipePkg::stageCtrl_t ifCtrl,
    input pipePkg::stageCtrl_t idCtrl,
    input pipePkg::stageCtrl_t exeCtrl,
    input pipePkg::stageCtrl_t memCtrl,
    input pipePkg::stageCtrl_t mem2Ctrl,
    input pipePkg::stageCtrl_t wbCtrl
);

    logic anyBusy;
    logic anyWr;
    logic anyFlush;

    assign anyBusy  = iBusy || dBusy || iTlbStall || dTlbStall || mulDivBusy;
    assign anyWr    = preIfWr || ifCtrl.wr || idCtrl.wr || exeCtrl.wr
                   || memCtrl.wr || mem2Ctrl.wr || wbCtrl.wr;
    assign anyFlush = ifCtrl.flush || idCtrl.flush || exeCtrl.flush
                   || memCtrl.flush || mem2Ctrl.flush || wbCtrl.flush;

    noWrOnDBusy: assert property (@(posedge clk) disable iff (!rstN) dBusy |-> !anyWr)
        else $error("stage write enable raised while the data cache is busy");

    wbHeldOnBusy: assert property (@(posedge clk) disable iff (!rstN) anyBusy |-> wbCtrl.disWr)
        else $error("wb side effects enabled during a busy freeze");

    frozenQuiet: assert property (@(posedge clk) disable iff (!rstN)
        anyBusy |-> !anyFlush && exeCtrl.disWr && memCtrl.disWr)
        else $error("flush or exe/mem side effect during a busy freeze");

endmodule

// controller ports as seen in pipeTop
bind pipeTop pipeProps props0 (.*);

`default_nettype wire

// File: verilog/fetchPc.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module fetchPc (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  preIfWr,
    input  logic                  excFlush,
    input  logic                  mispredict,
    input  logic [`PIPE_PC_W-1:0] mispTarget,
    output logic [`PIPE_PC_W-1:0] pc
);

    logic [`PIPE_PC_W-1:0] pcNext;

    always_comb begin
        pcNext = pc;                                  // hold by default
        if (excFlush == `PIPE_FLUSH_ENABLE) begin
            pcNext = `PIPE_EXC_VECTOR;                // exception wins
        end else if (mispredict) begin
            pcNext = mispTarget;
        end else if (preIfWr) begin
            pcNext = pc + `PIPE_PC_W'(4);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `PIPE_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazardDetect.sv
`timescale 1ns/1ps
`default_nettype none

module hazardDetect (
    input  pipePkg::instToken_t idTok,
    input  pipePkg::instToken_t exeTok,
    input  pipePkg::instToken_t memTok,
    input  pipePkg::instToken_t mem2Tok,
    output pipePkg::hazardReq_t hazard
);

    // load in a later stage whose result id still needs
    function automatic logic loadHit(
        input pipePkg::instToken_t prod,
        input pipePkg::instToken_t cons
    );
        logic isLoad;
        logic srcMatch;
        isLoad   = prod.valid
                && (prod.fields.kind == pipePkg::loadOp)
                && (prod.fields.dest != '0);          // r0 is never written
        srcMatch = (prod.fields.dest == cons.fields.src1)
                || (prod.fields.dest == cons.fields.src2);
        return isLoad && cons.valid && srcMatch;
    endfunction

    always_comb begin
        hazard.withExe  = loadHit(exeTok, idTok);
        hazard.withMem  = loadHit(memTok, idTok);
        hazard.withMem2 = loadHit(mem2Tok, idTok);
    end

endmodule

`default_nettype wire

// File: verilog/mulDivSeq.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module mulDivSeq (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::instToken_t exeTok,
    input  pipePkg::stageCtrl_t exeCtrl,
    output logic                busy
);

    localparam int CntW = (`PIPE_MULDIV_CYC > 1) ? $clog2(`PIPE_MULDIV_CYC) : 1;

    logic [CntW-1:0] cnt;
    logic            done;
    logic            start;

    assign start = exeTok.valid
                && (exeTok.fields.kind == pipePkg::mulDivOp)
                && !exeCtrl.disWr
                && !busy
                && !done;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
                cnt  <= CntW'(`PIPE_MULDIV_CYC - 1);  // remaining busy cycles
            end else if (busy) begin
                if (cnt == '0) begin
                    busy <= 1'b0;
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
            if (exeCtrl.wr) begin
                done <= 1'b0;                // new exe token
            end else if (start) begin
                done <= 1'b1;                // token served so no rerun while held
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipeCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipeCtrl (
    input  logic                excFlush,
    input  logic                iTlbStall,
    input  logic                dTlbStall,
    input  logic                iBusy,
    input  logic                dBusy,
    input  pipePkg::hazardReq_t hazard,
    input  logic                mispredict,
    input  logic                mulDivBusy,
    output logic                preIfWr,
    output pipePkg::stageCtrl_t ifCtrl,
    output pipePkg::stageCtrl_t idCtrl,
    output pipePkg::stageCtrl_t exeCtrl,
    output pipePkg::stageCtrl_t memCtrl,
    output pipePkg::stageCtrl_t mem2Ctrl,
    output pipePkg::stageCtrl_t wbCtrl,
    output logic                iReqValid,
    output logic                dReqValid,
    output logic                iCacheStall,
    output logic                dCacheStall
);

    logic anyBusy;
    logic excActive;
    logic anyHazard;

    assign anyBusy   = dBusy || dTlbStall || iBusy || iTlbStall || mulDivBusy;
    assign excActive = (excFlush == `PIPE_FLUSH_ENABLE);
    assign anyHazard = hazard.withExe || hazard.withMem || hazard.withMem2;

    function automatic pipePkg::stageCtrl_t ctl(input logic w, input logic f, input logic d);
        return '{wr: w, flush: f, disWr: d};
    endfunction

    // no fetch request while the front end is dropped or held
    assign iReqValid = !(excActive || anyHazard || mispredict);
    assign dReqValid = !excActive;

    // cache keeps its data until the core takes it
    assign dCacheStall = anyBusy;
    assign iCacheStall = anyBusy || (!excActive && anyHazard);

    always_comb begin
        if (anyBusy) begin                       // dcache/dtlb, icache/itlb, mul/div
            preIfWr  = 1'b0;
            ifCtrl   = ctl(1'b0, 1'b0, 1'b0);
            idCtrl   = ctl(1'b0, 1'b0, 1'b0);
            exeCtrl  = ctl(1'b0, 1'b0, 1'b1);
            memCtrl  = ctl(1'b0, 1'b0, 1'b1);
            mem2Ctrl = ctl(1'b0, 1'b0, 1'b0);
            wbCtrl   = ctl(1'b0, 1'b0, 1'b1);    // held wb token must not retire
        end else if (excActive) begin
            preIfWr  = 1'b1;
            ifCtrl   = ctl(1'b0, 1'b1, 1'b0);
            idCtrl   = ctl(1'b0, 1'b1, 1'b0);
            exeCtrl  = ctl(1'b0, 1'b1, 1'b1);
            memCtrl  = ctl(1'b0, 1'b1, 1'b1);
            mem2Ctrl = ctl(1'b1, 1'b0, 1'b0);    // older work drains
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end else if (hazard.withMem2) begin
            preIfWr  = 1'b0;
            ifCtrl   = ctl(1'b0, 1'b0, 1'b0);
            idCtrl   = ctl(1'b0, 1'b0, 1'b0);
            exeCtrl  = ctl(1'b0, 1'b0, 1'b0);
            memCtrl  = ctl(1'b0, 1'b0, 1'b1);
            mem2Ctrl = ctl(1'b1, 1'b1, 1'b0);    // load moves to wb with a bubble behind
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end else if (hazard.withMem) begin
            preIfWr  = 1'b0;
            ifCtrl   = ctl(1'b0, 1'b0, 1'b0);
            idCtrl   = ctl(1'b0, 1'b0, 1'b0);
            exeCtrl  = ctl(1'b0, 1'b0, 1'b1);
            memCtrl  = ctl(1'b1, 1'b1, 1'b0);
            mem2Ctrl = ctl(1'b1, 1'b0, 1'b0);
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end else if (hazard.withExe) begin
            preIfWr  = 1'b0;
            ifCtrl   = ctl(1'b0, 1'b0, 1'b0);
            idCtrl   = ctl(1'b0, 1'b0, 1'b0);
            exeCtrl  = ctl(1'b1, 1'b1, 1'b0);
            memCtrl  = ctl(1'b1, 1'b0, 1'b0);
            mem2Ctrl = ctl(1'b1, 1'b0, 1'b0);
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end else if (mispredict) begin
            preIfWr  = 1'b1;
            ifCtrl   = ctl(1'b0, 1'b1, 1'b0);    // wrong-path fetches
            idCtrl   = ctl(1'b0, 1'b1, 1'b0);
            exeCtrl  = ctl(1'b1, 1'b0, 1'b0);    // delay slot stays
            memCtrl  = ctl(1'b1, 1'b0, 1'b0);
            mem2Ctrl = ctl(1'b1, 1'b0, 1'b0);
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end else begin
            preIfWr  = 1'b1;
            ifCtrl   = ctl(1'b1, 1'b0, 1'b0);
            idCtrl   = ctl(1'b1, 1'b0, 1'b0);
            exeCtrl  = ctl(1'b1, 1'b0, 1'b0);
            memCtrl  = ctl(1'b1, 1'b0, 1'b0);
            mem2Ctrl = ctl(1'b1, 1'b0, 1'b0);
            wbCtrl   = ctl(1'b1, 1'b0, 1'b0);
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipePkg.sv
`default_nettype none

`include "pipe_defines.svh"

package pipePkg;

    typedef enum logic [1:0] {
        aluOp    = 2'd0,
        loadOp   = 2'd1,
        storeOp  = 2'd2,
        mulDivOp = 2'd3
    } instKind_t;

    typedef struct packed {
        instKind_t              kind;
        logic [`PIPE_REG_W-1:0] src1;
        logic [`PIPE_REG_W-1:0] src2;
        logic [`PIPE_REG_W-1:0] dest;    // r0 never produces a hazard
    } instFields_t;

    typedef struct packed {
        logic                  valid;
        logic [`PIPE_PC_W-1:0] pc;
        instFields_t           fields;
    } instToken_t;

    typedef struct packed {
        logic                  valid;    // cleared by flush
        logic [`PIPE_PC_W-1:0] pc;
    } pcToken_t;

    typedef struct packed {
        logic wr;
        logic flush;                     // wins over wr
        logic disWr;                     // kills side effects of the stage
    } stageCtrl_t;

    typedef struct packed {
        logic withExe;
        logic withMem;
        logic withMem2;
    } hazardReq_t;

endpackage

`default_nettype wire

// File: verilog/pipeTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module pipeTop (
    input  logic                   clk,
    input  logic                   rstN,
    input  pipePkg::instFields_t   fetchInst,
    input  logic                   excFlush,
    input  logic                   mispredict,
    input  logic [`PIPE_PC_W-1:0]  mispTarget,
    input  logic                   iBusy,
    input  logic                   dBusy,
    input  logic                   iTlbStall,
    input  logic                   dTlbStall,
    output logic                   wbRetire,
    output logic [`PIPE_PC_W-1:0]  wbPc,
    output logic [`PIPE_REG_W-1:0] wbDest,
    output logic                   iReqValid,
    output logic                   dReqValid,
    output logic                   iCacheStall,
    output logic                   dCacheStall
);

    pipePkg::stageCtrl_t   ifCtrl;
    pipePkg::stageCtrl_t   idCtrl;
    pipePkg::stageCtrl_t   exeCtrl;
    pipePkg::stageCtrl_t   memCtrl;
    pipePkg::stageCtrl_t   mem2Ctrl;
    pipePkg::stageCtrl_t   wbCtrl;
    pipePkg::hazardReq_t   hazard;
    pipePkg::pcToken_t     ifNext;
    pipePkg::pcToken_t     ifTok;
    pipePkg::instToken_t   idNext;
    pipePkg::instToken_t   idTok;
    pipePkg::instToken_t   exeTok;
    pipePkg::instToken_t   memTok;
    pipePkg::instToken_t   mem2Tok;
    pipePkg::instToken_t   wbTok;
    logic [`PIPE_PC_W-1:0] preIfPc;
    logic                  preIfWr;
    logic                  mulDivBusy;
    logic                  dReqCtrl;
    logic                  memIsLdSt;

    pipeCtrl ctrl (
        .excFlush, .iTlbStall, .dTlbStall, .iBusy, .dBusy, .hazard, .mispredict,
        .mulDivBusy, .preIfWr, .ifCtrl, .idCtrl, .exeCtrl, .memCtrl, .mem2Ctrl, .wbCtrl,
        .iReqValid, .dReqValid(dReqCtrl), .iCacheStall, .dCacheStall
    );

    fetchPc pcGen (
        .clk, .rstN, .preIfWr, .excFlush, .mispredict, .mispTarget, .pc(preIfPc)
    );

    assign ifNext = '{valid: 1'b1, pc: preIfPc};
    assign idNext = '{valid: ifTok.valid, pc: ifTok.pc, fields: fetchInst};  // inst arrives in if

    stageReg #(.tokenT(pipePkg::pcToken_t)) ifReg (
        .clk, .rstN, .ctrl(ifCtrl), .d(ifNext), .q(ifTok)
    );
    stageReg #(.tokenT(pipePkg::instToken_t)) idReg (
        .clk, .rstN, .ctrl(idCtrl), .d(idNext), .q(idTok)
    );
    stageReg #(.tokenT(pipePkg::instToken_t)) exeReg (
        .clk, .rstN, .ctrl(exeCtrl), .d(idTok), .q(exeTok)
    );
    stageReg #(.tokenT(pipePkg::instToken_t)) memReg (
        .clk, .rstN, .ctrl(memCtrl), .d(exeTok), .q(memTok)
    );
    stageReg #(.tokenT(pipePkg::instToken_t)) mem2Reg (
        .clk, .rstN, .ctrl(mem2Ctrl), .d(memTok), .q(mem2Tok)
    );
    stageReg #(.tokenT(pipePkg::instToken_t)) wbReg (
        .clk, .rstN, .ctrl(wbCtrl), .d(mem2Tok), .q(wbTok)
    );

    hazardDetect hazDet (
        .idTok, .exeTok, .memTok, .mem2Tok, .hazard
    );

    mulDivSeq mulDiv (
        .clk, .rstN, .exeTok, .exeCtrl, .busy(mulDivBusy)
    );

    assign memIsLdSt = (memTok.fields.kind == pipePkg::loadOp)
                    || (memTok.fields.kind == pipePkg::storeOp);
    assign dReqValid = dReqCtrl && memTok.valid && memIsLdSt && !memCtrl.disWr;

    assign wbRetire = wbTok.valid && !wbCtrl.disWr;    // frozen wb token retires once
    assign wbPc     = wbTok.pc;
    assign wbDest   = wbTok.fields.dest;

endmodule

`default_nettype wire

// File: verilog/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// datapath widths
`define PIPE_PC_W 32
`define PIPE_REG_W 5

// boot address fetched first after reset
`define PIPE_RESET_PC 32'hBFC0_0000

// general exception entry
`define PIPE_EXC_VECTOR 32'hBFC0_0380

// cycles the pipeline stays frozen per mul/div
`define PIPE_MULDIV_CYC 4

// level of excFlush that means flush active
`define PIPE_FLUSH_ENABLE 1'b1

`endif

// File: verilog/stageReg.sv
`timescale 1ns/1ps
`default_nettype none

module stageReg #(
    parameter type tokenT = pipePkg::instToken_t
) (
    input  logic                clk,
    input  logic                rstN,
    input  pipePkg::stageCtrl_t ctrl,
    input  tokenT               d,
    output tokenT               q
);

    // an all-zero token is an empty slot
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (ctrl.flush) begin
            q <= '0;                 // bubble
        end else if (ctrl.wr) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire
